// ==== src/camPkg.sv ====
package camPkg;

	localparam int phasesPerPixel = 10; // clock cycles per pixel period
	localparam int mClockHighLast = 4; // mClock high on phases 0..4
	localparam int adcClockFirst = 2; // adc clock rises here
	localparam int adcClockLast = 6; // and stays high through this phase
	localparam int samplePhase = 6; // acData captured at the end of this phase

	localparam int pixelsPerLine = 16; // active columns
	localparam int lineBlank = 4; // blank pixel periods after the active columns
	localparam int linesPerFrame = 8;
	localparam int fsyncPeriods = 4; // frame sync periods before line 0
	localparam int periodsPerLine = pixelsPerLine + lineBlank;
	localparam int framePeriods = fsyncPeriods + linesPerFrame * periodsPerLine;

	localparam int colWidth = 5; // column field of an event
	localparam int lineWidth = 4; // line field of an event
	localparam int adcWidth = 13; // raw adc word
	localparam int levelWidth = 10; // brightness and threshold
	localparam int fifoDepth = 16; // event records
	localparam int fifoPtrWidth = $clog2(fifoDepth);

	typedef enum logic [3:0] {
		ph0, ph1, ph2, ph3, ph4, ph5, ph6, ph7, ph8, ph9
	} pixelPhase; // position inside one pixel period

endpackage

// ==== src/busPkg.sv ====
package busPkg;

	localparam int addrWidth = 6;
	localparam int dataWidth = 8;

	typedef enum logic [addrWidth-1:0] {
		ctrlReg = 6'd0, // write go / clear overflow, read status
		threshLo = 6'd8, // threshold bits 7..0
		threshHi = 6'd9, // threshold bits 9..8
		hitColReg = 6'd14, // column of fifo head
		hitLineReg = 6'd15, // line of fifo head
		popReg = 6'd18 // write bit4 pops the fifo
	} regAddr;

	localparam int goBit = 0; // ctrlReg write bits
	localparam int clrOvfBit = 3;
	localparam int popBit = 4; // popReg write bit

	localparam int busyBit = 0; // status read bits
	localparam int emptyBit = 1;
	localparam int fullBit = 2;
	localparam int ovfBit = 3;

endpackage

// ==== src/frameTiming.sv ====
`timescale 1ns/1ps

module frameTiming (
	input  logic bls0we,
	input  logic resadd,
	input  logic goStb,
	output logic mClock,
	output logic mFSync,
	output logic mLSync,
	output logic adcClock,
	output logic busy,
	output logic sampleStb,
	output logic [camPkg::colWidth-1:0] sampleCol,
	output logic [camPkg::lineWidth-1:0] sampleLine
);
	import camPkg::*;

	pixelPhase phase, phaseNxt; // divider by phasesPerPixel
	logic [$clog2(framePeriods+1)-1:0] perCnt, perNxt; // pixel periods since go
	logic [colWidth-1:0] col, colNxt; // includes blank columns
	logic [lineWidth-1:0] line, lineNxt;
	logic busyNxt;
	logic inLines; // past the frame sync periods

	always_comb begin
		busyNxt = busy;
		phaseNxt = phase;
		perNxt = perCnt;
		colNxt = col;
		lineNxt = line;
		if (goStb) begin // accepted only while idle
			busyNxt = 1'b1;
			phaseNxt = ph0;
			perNxt = '0;
			colNxt = '0;
			lineNxt = '0;
		end else if (busy) begin
			if (phase == pixelPhase'(phasesPerPixel - 1)) begin // end of pixel period
				phaseNxt = ph0;
				perNxt = perCnt + 1'b1;
				if (perCnt == framePeriods - 1)
					busyNxt = 1'b0; // last period of the frame
				if (perCnt >= fsyncPeriods) begin // column count runs only inside lines
					if (col == periodsPerLine - 1) begin
						colNxt = '0;
						lineNxt = line + 1'b1;
					end else begin
						colNxt = col + 1'b1;
					end
				end
			end else begin
				phaseNxt = pixelPhase'(phase + 1'b1);
			end
		end
	end

	assign inLines = perNxt >= fsyncPeriods;

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			busy <= 1'b0;
			phase <= ph0;
			perCnt <= '0;
			col <= '0;
			line <= '0;
			mClock <= 1'b0;
			adcClock <= 1'b0;
			mFSync <= 1'b0;
			mLSync <= 1'b0;
			sampleStb <= 1'b0;
		end else begin
			busy <= busyNxt;
			phase <= phaseNxt;
			perCnt <= perNxt;
			col <= colNxt;
			line <= lineNxt;
			// outputs decoded from the next state so they line up with phase
			mClock <= busyNxt && (phaseNxt <= mClockHighLast);
			adcClock <= busyNxt && (phaseNxt >= adcClockFirst) && (phaseNxt <= adcClockLast);
			mFSync <= busyNxt && !inLines; // first fsyncPeriods pixel periods
			mLSync <= busyNxt && inLines && (colNxt == 0); // whole period of column 0
			sampleStb <= busyNxt && inLines && (phaseNxt == samplePhase)
				&& (colNxt < pixelsPerLine); // blank columns are not sampled
		end
	end

	always_ff @(posedge bls0we) begin
		sampleCol <= colNxt; // only meaningful with sampleStb
		sampleLine <= lineNxt;
	end

endmodule

// ==== src/pixelThreshold.sv ====
`timescale 1ns/1ps

module pixelThreshold (
	input  logic bls0we,
	input  logic resadd,
	input  logic sampleStb,
	input  logic [camPkg::colWidth-1:0] sampleCol,
	input  logic [camPkg::lineWidth-1:0] sampleLine,
	input  logic [camPkg::adcWidth-1:0] acData,
	input  logic [camPkg::levelWidth-1:0] threshold,
	output logic hitStb,
	output logic [camPkg::colWidth-1:0] hitCol,
	output logic [camPkg::lineWidth-1:0] hitLine
);
	import camPkg::*;

	logic sampleVld; // level holds a fresh sample
	logic [levelWidth-1:0] level; // brightness of the last sample

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			sampleVld <= 1'b0;
		end else begin
			sampleVld <= sampleStb; // one cycle behind the strobe
		end
	end

	// sensor output is dark-high, so brightness is the inverted field
	always_ff @(posedge bls0we) begin
		if (sampleStb) begin
			level <= ~acData[levelWidth+1:2]; // adc bits 11..2
			hitCol <= sampleCol;
			hitLine <= sampleLine;
		end
	end

	assign hitStb = sampleVld && (level >= threshold); // threshold 0 passes every pixel

endmodule

// ==== src/hitFifo.sv ====
`timescale 1ns/1ps

module hitFifo (
	input  logic bls0we,
	input  logic resadd,
	input  logic hitStb,
	input  logic [camPkg::colWidth-1:0] hitCol,
	input  logic [camPkg::lineWidth-1:0] hitLine,
	input  logic popStb,
	input  logic clearOvf,
	output logic [camPkg::colWidth-1:0] headCol,
	output logic [camPkg::lineWidth-1:0] headLine,
	output logic empty,
	output logic full,
	output logic overflow
);
	import camPkg::*;

	logic [colWidth-1:0] colMem [fifoDepth];
	logic [lineWidth-1:0] lineMem [fifoDepth];
	logic [fifoPtrWidth:0] wrPtr, rdPtr; // extra msb tells full from empty
	logic push, pop;

	assign empty = wrPtr == rdPtr;
	assign full = (wrPtr[fifoPtrWidth] != rdPtr[fifoPtrWidth])
		&& (wrPtr[fifoPtrWidth-1:0] == rdPtr[fifoPtrWidth-1:0]);
	assign push = hitStb && !full; // dropped when full
	assign pop = popStb && !empty; // pop on empty ignored

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			wrPtr <= '0;
			rdPtr <= '0;
			overflow <= 1'b0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			if (hitStb && full) overflow <= 1'b1; // new loss wins over a clear
			else if (clearOvf) overflow <= 1'b0;
		end
	end

	always_ff @(posedge bls0we) begin
		if (push) begin
			colMem[wrPtr[fifoPtrWidth-1:0]] <= hitCol;
			lineMem[wrPtr[fifoPtrWidth-1:0]] <= hitLine;
		end
	end

	assign headCol = colMem[rdPtr[fifoPtrWidth-1:0]]; // stale while empty
	assign headLine = lineMem[rdPtr[fifoPtrWidth-1:0]];

endmodule

// ==== src/cpuRegs.sv ====
`timescale 1ns/1ps

module cpuRegs (
	input  logic bls0we,
	input  logic resadd,
	input  logic [busPkg::addrWidth-1:0] addr,
	input  logic wrStb,
	input  logic [busPkg::dataWidth-1:0] wrData,
	input  logic rdStb,
	input  logic busy,
	input  logic empty,
	input  logic full,
	input  logic overflow,
	input  logic [camPkg::colWidth-1:0] headCol,
	input  logic [camPkg::lineWidth-1:0] headLine,
	output logic [busPkg::dataWidth-1:0] rdData,
	output logic goStb,
	output logic popStb,
	output logic clearOvf,
	output logic [camPkg::levelWidth-1:0] threshold
);
	import camPkg::*;
	import busPkg::*;

	regAddr regSel; // decoded address
	logic wrCtrl; // write to the control register
	logic [dataWidth-1:0] status;

	assign regSel = regAddr'(addr);
	assign wrCtrl = wrStb && (regSel == ctrlReg);

	// strobes act at the edge of the write cycle
	assign goStb = wrCtrl && wrData[goBit] && !busy; // no restart mid-frame
	assign clearOvf = wrCtrl && wrData[clrOvfBit];
	assign popStb = wrStb && (regSel == popReg) && wrData[popBit];

	always_comb begin
		status = '0; // upper bits read as zero
		status[busyBit] = busy;
		status[emptyBit] = empty;
		status[fullBit] = full;
		status[ovfBit] = overflow;
	end

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			threshold <= '0;
		end else if (wrStb) begin
			if (regSel == threshLo)
				threshold[dataWidth-1:0] <= wrData;
			else if (regSel == threshHi)
				threshold[levelWidth-1:dataWidth] <= wrData[levelWidth-dataWidth-1:0];
		end
	end

	// read data held until the next read strobe
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			rdData <= '0;
		end else if (rdStb) begin
			case (regSel)
				ctrlReg: rdData <= status;
				threshLo: rdData <= threshold[dataWidth-1:0];
				threshHi: rdData <= dataWidth'(threshold[levelWidth-1:dataWidth]);
				hitColReg: rdData <= dataWidth'(headCol); // zero extended
				hitLineReg: rdData <= dataWidth'(headLine);
				default: rdData <= '0; // popReg and unmapped addresses
			endcase
		end
	end

endmodule

// ==== src/camCtrl.sv ====
`timescale 1ns/1ps

module camCtrl (
	input  logic bls0we,
	input  logic resadd,
	input  logic [busPkg::addrWidth-1:0] addr,
	input  logic wrStb,
	input  logic [busPkg::dataWidth-1:0] wrData,
	input  logic rdStb,
	input  logic [camPkg::adcWidth-1:0] acData,
	output logic [busPkg::dataWidth-1:0] rdData,
	output logic mClock,
	output logic mFSync,
	output logic mLSync,
	output logic adcClock,
	output logic busyLed
);
	import camPkg::*;

	logic goStb, popStb, clearOvf; // cpu strobes
	logic busy;
	logic sampleStb;
	logic [colWidth-1:0] sampleCol, hitCol, headCol;
	logic [lineWidth-1:0] sampleLine, hitLine, headLine;
	logic hitStb;
	logic empty, full, overflow;
	logic [levelWidth-1:0] threshold;

	frameTiming timing_i (.bls0we, .resadd, .goStb, .mClock, .mFSync, .mLSync,
		.adcClock, .busy, .sampleStb, .sampleCol, .sampleLine);

	pixelThreshold thresh_i (.bls0we, .resadd, .sampleStb, .sampleCol, .sampleLine,
		.acData, .threshold, .hitStb, .hitCol, .hitLine);

	hitFifo fifo_i (.bls0we, .resadd, .hitStb, .hitCol, .hitLine, .popStb, .clearOvf,
		.headCol, .headLine, .empty, .full, .overflow);

	cpuRegs regs_i (.bls0we, .resadd, .addr, .wrStb, .wrData, .rdStb, .busy, .empty,
		.full, .overflow, .headCol, .headLine, .rdData, .goStb, .popStb, .clearOvf,
		.threshold);

	assign busyLed = busy; // lit for the whole frame

endmodule

// ==== testbench/camCheck.sv ====
`timescale 1ns/1ps

module camCheck (
	input  logic bls0we,
	input  logic resadd,
	input  logic mClock,
	input  logic mFSync,
	input  logic mLSync,
	input  logic adcClock,
	input  logic busyLed,
	input  logic [camPkg::adcWidth-1:0] acData,
	input  logic [busPkg::dataWidth-1:0] rdData,
	input  logic [camPkg::levelWidth-1:0] expThresh,
	input  logic chkStb,
	input  logic [2:0] chkKind,
	input  logic [busPkg::dataWidth-1:0] chkExp,
	input  logic [busPkg::dataWidth-1:0] chkMask,
	output int valErrs,
	output int otherErrs
);
	import camPkg::*;
	import busPkg::*;

	localparam logic [2:0] kStatus = 3'd0; // read compares, same codes as the testbench
	localparam logic [2:0] kThrLo = 3'd1;
	localparam logic [2:0] kThrHi = 3'd2;
	localparam logic [2:0] kHitCol = 3'd3;
	localparam logic [2:0] kHitLine = 3'd4;
	localparam logic [2:0] kDrained = 3'd5; // all expected hits read
	localparam logic [2:0] kFlush = 3'd6; // drop hits lost to overflow

	localparam int frameCycles = framePeriods * phasesPerPixel;
	localparam int adcHighCycles = framePeriods * (adcClockLast - adcClockFirst + 1);

	logic [lineWidth+colWidth-1:0] hitQ [$]; // {line, col} in scan order
	logic prevMc, prevAdc, prevLs, prevBusy;
	int col, line; // pixel the sensor is showing
	int busyCnt, fsCnt, lsCnt, mcCnt, adcCnt;
	logic [levelWidth-1:0] bright;

	function automatic void compareByte(input string name, input logic [dataWidth-1:0] exp,
		input logic [dataWidth-1:0] act, input logic [dataWidth-1:0] mask);
		if ((exp & mask) !== (act & mask)) begin
			$display("ERR %s exp %h act %h", name, exp & mask, act & mask);
			valErrs++;
		end
	endfunction

	function automatic void compareCount(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s exp %h act %h", name, exp, act);
			valErrs++;
		end
	endfunction

	always @(posedge bls0we) begin
		if (resadd) begin
			valErrs = 0;
			otherErrs = 0;
			prevMc = 1'b0;
			prevAdc = 1'b0;
			prevLs = 1'b0;
			prevBusy = 1'b0;
			busyCnt = 0;
			fsCnt = 0;
			lsCnt = 0;
			mcCnt = 0;
			adcCnt = 0;
			hitQ.delete();
		end else begin
			if (!busyLed && (mClock || mFSync || mLSync || adcClock)) begin
				$display("sensor output active while the controller is idle");
				otherErrs++;
			end
			if (mClock && !prevMc) begin // new pixel period
				if (mFSync) begin
					line = -1;
					col = 0;
				end else if (mLSync) begin
					line = line + 1;
					col = 0;
				end else begin
					col = col + 1;
				end
			end
			// adc clock fell one edge ago, that edge captured acData
			if (prevAdc && !adcClock && line >= 0 && line < linesPerFrame
				&& col < pixelsPerLine) begin
				bright = ~acData[11:2];
				if (bright >= expThresh)
					hitQ.push_back({line[lineWidth-1:0], col[colWidth-1:0]});
			end
			if (busyLed) begin
				busyCnt++;
				if (mFSync) fsCnt++;
				if (mLSync && !prevLs) lsCnt++;
				if (mClock && !prevMc) mcCnt++;
				if (adcClock) adcCnt++;
			end
			if (prevBusy && !busyLed) begin // frame just ended
				compareCount("busyLed high cycles", frameCycles, busyCnt);
				compareCount("mFSync high cycles", fsyncPeriods * phasesPerPixel, fsCnt);
				compareCount("mLSync pulses", linesPerFrame, lsCnt);
				compareCount("mClock periods", framePeriods, mcCnt);
				compareCount("adcClock high cycles", adcHighCycles, adcCnt);
				busyCnt = 0;
				fsCnt = 0;
				lsCnt = 0;
				mcCnt = 0;
				adcCnt = 0;
			end
			if (chkStb) begin
				case (chkKind)
					kStatus: compareByte("rdData(status)", chkExp, rdData, chkMask);
					kThrLo: compareByte("rdData(threshLo)", chkExp, rdData, chkMask);
					kThrHi: compareByte("rdData(threshHi)", chkExp, rdData, chkMask);
					kHitCol, kHitLine: begin
						if (hitQ.size() == 0) begin
							$display("hit register read although no hit was expected");
							otherErrs++;
						end else if (chkKind == kHitCol) begin
							compareByte("rdData(hitCol)", dataWidth'(hitQ[0][colWidth-1:0]),
								rdData, 8'hFF);
						end else begin
							compareByte("rdData(hitLine)",
								dataWidth'(hitQ[0][lineWidth+colWidth-1:colWidth]), rdData, 8'hFF);
							void'(hitQ.pop_front()); // line read closes the record
						end
					end
					kDrained: if (hitQ.size() != 0) begin
						$display("%0d expected hits were never read back", hitQ.size());
						otherErrs++;
					end
					kFlush: begin
						if (hitQ.size() == 0) begin
							$display("frame gave no more hits than the FIFO holds");
							otherErrs++;
						end
						hitQ.delete();
					end
					default: ;
				endcase
			end
			prevMc = mClock;
			prevAdc = adcClock;
			prevLs = mLSync;
			prevBusy = busyLed;
		end
	end

endmodule

// ==== testbench/camCtrl_asserts.sv ====
`timescale 1ns/1ps

module camCtrlAsserts (
	input logic bls0we,
	input logic resadd,
	input logic mClock,
	input logic mLSync,
	input logic adcClock,
	input logic hitStb,
	input logic clearOvf,
	input logic empty,
	input logic overflow
);
	import camPkg::*;

	lineOnClock: assert property (@(posedge bls0we) disable iff (resadd)
		$rose(mLSync) |-> $rose(mClock)) else $error("line sync rose without the pixel clock");

	// high for exactly one pixel period before it falls
	lineOnePixel: assert property (@(posedge bls0we) disable iff (resadd)
		$fell(mLSync) |-> $past(mLSync, phasesPerPixel)
			&& !$past(mLSync, phasesPerPixel + 1))
		else $error("line sync not high for one pixel period");

	adcAfterClock: assert property (@(posedge bls0we) disable iff (resadd)
		$rose(adcClock) |-> $past(mClock, adcClockFirst)
			&& !$past(mClock, adcClockFirst + 1))
		else $error("adc clock rose at the wrong pixel phase");

	popEmptyIgnored: assert property (@(posedge bls0we) disable iff (resadd)
		(empty && !hitStb) |=> empty) else $error("FIFO left empty without a push");

	ovfSticky: assert property (@(posedge bls0we) disable iff (resadd)
		(overflow && !clearOvf) |=> overflow)
		else $error("overflow cleared without a clear write");

endmodule

bind camCtrl camCtrlAsserts asserts_i (.bls0we, .resadd, .mClock, .mLSync, .adcClock,
	.hitStb, .clearOvf, .empty, .overflow);

// ==== testbench/camCtrlTb.sv ====
`timescale 1ns/1ps

module camCtrlTb;
	import camPkg::*;
	import busPkg::*;

	localparam int frameWords = 1 + linesPerFrame * pixelsPerLine; // threshold + samples
	localparam int busAccesses = 160;
	localparam int cycleLimit = 2 * framePeriods * phasesPerPixel + 20 * busAccesses + 500;
	localparam logic [2:0] kStatus = 3'd0;
	localparam logic [2:0] kThrLo = 3'd1;
	localparam logic [2:0] kThrHi = 3'd2;
	localparam logic [2:0] kHitCol = 3'd3;
	localparam logic [2:0] kHitLine = 3'd4;
	localparam logic [2:0] kDrained = 3'd5;
	localparam logic [2:0] kFlush = 3'd6;

	logic bls0we, resadd;
	logic [addrWidth-1:0] addr;
	logic wrStb, rdStb;
	logic [dataWidth-1:0] wrData, rdData, lastRead;
	logic [adcWidth-1:0] acData;
	logic mClock, mFSync, mLSync, adcClock, busyLed;
	logic [15:0] pixTable [2*frameWords];
	logic [levelWidth-1:0] expThresh;
	logic chkStb;
	logic [2:0] chkKind;
	logic [dataWidth-1:0] chkExp, chkMask;
	int valErrs, otherErrs;
	int frameSel, senseCol, senseLine;
	logic mClockPrev;
	int cycles = 0;

	camCtrl dut_i (.bls0we, .resadd, .addr, .wrStb, .wrData, .rdStb, .acData, .rdData,
		.mClock, .mFSync, .mLSync, .adcClock, .busyLed);

	camCheck chk_i (.bls0we, .resadd, .mClock, .mFSync, .mLSync, .adcClock, .busyLed,
		.acData, .rdData, .expThresh, .chkStb, .chkKind, .chkExp, .chkMask, .valErrs,
		.otherErrs);

	initial begin
		bls0we = 1'b0;
		forever #5 bls0we = ~bls0we;
	end

	always @(posedge bls0we) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, the test did not finish", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// sensor model, next pixel on every mClock rise
	always @(posedge bls0we) begin
		mClockPrev <= mClock;
		if (mClock && !mClockPrev) begin
			if (mFSync) begin
				senseLine = -1;
				senseCol = 0;
			end else if (mLSync) begin
				senseLine = senseLine + 1;
				senseCol = 0;
			end else begin
				senseCol = senseCol + 1;
			end
			if (senseLine >= 0 && senseLine < linesPerFrame && senseCol < pixelsPerLine)
				acData <= pixTable[frameSel*frameWords + 1 + senseLine*pixelsPerLine
					+ senseCol][adcWidth-1:0];
			else
				acData <= '1; // blank columns read dark
		end
	end

	task automatic writeReg(input regAddr a, input logic [dataWidth-1:0] d);
		@(posedge bls0we);
		addr <= a;
		wrData <= d;
		wrStb <= 1'b1;
		@(posedge bls0we);
		wrStb <= 1'b0;
	endtask

	// read, then hand rdData to the checker on the cycle after the strobe
	task automatic checkRead(input regAddr a, input logic [2:0] kind,
		input logic [dataWidth-1:0] exp, input logic [dataWidth-1:0] mask);
		@(posedge bls0we);
		addr <= a;
		rdStb <= 1'b1;
		@(posedge bls0we);
		rdStb <= 1'b0;
		chkStb <= 1'b1;
		chkKind <= kind;
		chkExp <= exp;
		chkMask <= mask;
		@(posedge bls0we);
		chkStb <= 1'b0;
		lastRead = rdData;
	endtask

	task automatic notifyCheck(input logic [2:0] kind);
		@(posedge bls0we);
		chkStb <= 1'b1;
		chkKind <= kind;
		chkMask <= '0;
		@(posedge bls0we);
		chkStb <= 1'b0;
	endtask

	task automatic runFrame(input int f, input bit retry);
		logic [15:0] t;
		t = pixTable[f*frameWords];
		frameSel = f;
		expThresh <= t[levelWidth-1:0];
		writeReg(threshLo, t[7:0]);
		writeReg(threshHi, {6'b0, t[9:8]});
		checkRead(threshLo, kThrLo, t[7:0], 8'hFF);
		checkRead(threshHi, kThrHi, {6'b0, t[9:8]}, 8'hFF);
		writeReg(ctrlReg, 8'h01); // go
		if (retry) begin
			repeat (100) @(posedge bls0we);
			writeReg(ctrlReg, 8'h01); // must not restart the frame
		end
		@(posedge bls0we);
		while (busyLed) @(posedge bls0we);
		repeat (4) @(posedge bls0we);
	endtask

	task automatic readHit();
		checkRead(hitColReg, kHitCol, '0, '0);
		checkRead(hitLineReg, kHitLine, '0, '0);
		writeReg(popReg, 8'h10);
	endtask

	initial begin
		resadd = 1'b1;
		addr = '0;
		wrStb = 1'b0;
		wrData = '0;
		rdStb = 1'b0;
		acData = '1;
		expThresh = '0;
		chkStb = 1'b0;
		chkKind = '0;
		chkExp = '0;
		chkMask = '0;
		frameSel = 0;
		$readmemh("testbench/camCtrl_input.txt", pixTable);
		repeat (16) @(posedge bls0we);
		resadd <= 1'b0;
		checkRead(ctrlReg, kStatus, 8'h02, 8'h0F); // idle and empty
		runFrame(0, 1'b0);
		for (int i = 0; i <= fifoDepth; i++) begin
			checkRead(ctrlReg, kStatus, 8'h00, 8'h0D); // idle, not full, no overflow
			if (lastRead[emptyBit]) break;
			readHit();
		end
		notifyCheck(kDrained);
		checkRead(ctrlReg, kStatus, 8'h02, 8'h0F);
		runFrame(1, 1'b1); // low threshold, more hits than the FIFO holds
		checkRead(ctrlReg, kStatus, 8'h0C, 8'h0F); // full with overflow
		for (int i = 0; i < fifoDepth; i++) readHit();
		checkRead(ctrlReg, kStatus, 8'h0A, 8'h0F); // empty with overflow
		notifyCheck(kFlush);
		writeReg(ctrlReg, 8'h08);
		checkRead(ctrlReg, kStatus, 8'h02, 8'h0F);
		repeat (2) @(posedge bls0we);
		$display("errors: %0d value mismatches, %0d other failures", valErrs, otherErrs);
		if (valErrs + otherErrs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== testbench/camCtrl_input.txt ====
// per frame: threshold word, then 8 lines of 16 ADC samples, column 0 first
// brightness is the inverted sample bits 11..2
0300
1FFF 1FFF 0100 1FFF 1FFF 1FFF 1FFF 1FFF 0400 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 03FC
0000 1FFF 1FFF 1FFF 1FFF 0F00 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1200 1200 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
1FFF 1FFF 1FFF 0400 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 0100 1FFF 1FFF 1FFF
03FC 0401 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF 1FFF
0010
0800 1FFF 0FBC 1FFF 0FC0 0800 1FFF 1FFF 0800 1FFF 1FFF 0FC0 1FFF 1FFF 0800 1FFF
1FFF 0800 1FFF 0FBC 1FFF 1FFF 0800 0FC0 1FFF 1FFF 0800 1FFF 1FFF 1FFF 1FFF 0800
0800 0800 1FFF 1FFF 1FFF 0FBC 1FFF 1FFF 1FFF 0800 1FFF 1FFF 0FC0 0800 1FFF 1FFF
1FFF 1FFF 0800 1FFF 0800 1FFF 1FFF 0800 1FFF 1FFF 1FFF 0800 1FFF 1FFF 0FBC 1FFF
0FC0 1FFF 1FFF 0800 1FFF 1FFF 0800 1FFF 0800 1FFF 1FFF 1FFF 0800 1FFF 1FFF 1FFF
1FFF 0800 1FFF 1FFF 1FFF 0800 1FFF 1FFF 1FFF 0FBC 1FFF 1FFF 1FFF 0800 1FFF 1FFF
0800 1FFF 1FFF 0FC0 0800 1FFF 1FFF 1FFF 0800 1FFF 0800 1FFF 1FFF 1FFF 0800 1FFF
1FFF 1FFF 0800 1FFF 1FFF 1FFF 0FBC 1FFF 1FFF 0800 1FFF 1FFF 0800 1FFF 1FFF 0800

// ==== camCtrl.f ====
src/camPkg.sv
src/busPkg.sv
src/frameTiming.sv
src/pixelThreshold.sv
src/hitFifo.sv
src/cpuRegs.sv
src/camCtrl.sv
testbench/camCheck.sv
testbench/camCtrl_asserts.sv
testbench/camCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the camCtrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module camCtrlTb \
	-f camCtrl.f -o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out="$(./obj_dir/simv)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx '>>> PASS' <<< "$out"; then
	exit 0
fi
exit 1
